//--- hdl/bt_link_pkg.sv
/*
	Sensor to Bluetooth link: shared sizes, timing limits and packet types
*/
`default_nettype none

package bt_link_pkg;

	localparam int NUM_CHANNELS = 4;
	localparam int CHAN_BITS = 2;
	localparam int SAMPLE_BITS = 110;
	localparam int PACKET_BYTES = 16;
	localparam int BYTE_IDX_BITS = 4;
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
	localparam int FIFO_COUNT_BITS = $clog2(FIFO_DEPTH + 1);
	localparam int TIMER_BITS = 10;
	localparam int UART_FRAME_BITS = 10;

	// Idle time after a packet, cut down for simulation
	localparam int PACKET_GAP_CYCLES = 64;
	localparam int PKT_GAP_BITS = $clog2(PACKET_GAP_CYCLES + 1);
	localparam int GAP_BITS = (PKT_GAP_BITS > TIMER_BITS) ? PKT_GAP_BITS : TIMER_BITS;

	typedef logic [SAMPLE_BITS-1:0] sample_t;
	typedef logic [CHAN_BITS-1:0] chan_t;

	typedef struct packed {
		logic [7:0] header;
		logic [1:0] pad;
		sample_t sample;
		logic [7:0] trailer;
	} packet_fields_t;

	// Entry 0 is the most significant byte, sent first
	typedef union packed {
		packet_fields_t fields;
		logic [0:PACKET_BYTES-1][7:0] bytes;
	} packet_u;

	typedef struct packed {
		logic [TIMER_BITS-1:0] cycles_per_bit;
		logic [TIMER_BITS-1:0] byte_gap;
	} link_cfg_t;

endpackage

`default_nettype wire

//--- hdl/sample_fifo.sv
/*
	Sample FIFO for one sensor channel, drops writes while full
*/
`timescale 1ns/1ps
`default_nettype none

module sample_fifo import bt_link_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic wr_i,
	input wire sample_t data_i,
	input wire logic rd_i,
	output sample_t data_o,
	output logic empty_o,
	output logic full_o
);

	sample_t mem [FIFO_DEPTH];
	logic [FIFO_PTR_BITS-1:0] wr_ptr_q;
	logic [FIFO_PTR_BITS-1:0] rd_ptr_q;
	logic [FIFO_COUNT_BITS-1:0] count_q;
	logic do_wr;
	logic do_rd;

	assign empty_o = (count_q == '0);
	assign full_o = (count_q == FIFO_COUNT_BITS'(FIFO_DEPTH));
	assign do_wr = wr_i && !full_o;
	assign do_rd = rd_i && !empty_o;

	// Head entry is visible without a read
	assign data_o = mem[rd_ptr_q];

	always_ff @(posedge clock)
	begin
		if (do_wr)
			mem[wr_ptr_q] <= data_i;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_rd)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (do_wr && !do_rd)
				count_q <= count_q + 1'b1;
			else if (do_rd && !do_wr)
				count_q <= count_q - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/channel_arbiter.sv
/*
	Round-robin arbiter, grants the next non-empty channel
	after the one served last
*/
`timescale 1ns/1ps
`default_nettype none

module channel_arbiter import bt_link_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic [NUM_CHANNELS-1:0] empty_i,
	input wire logic advance_i,
	output logic grant_valid_o,
	output chan_t grant_chan_o
);

	chan_t last_q;

	// Scan from the channel after last_q, wrapping round
	always_comb
	begin
		chan_t idx;
		grant_valid_o = 1'b0;
		grant_chan_o = last_q;
		for (int i = 1; i <= NUM_CHANNELS; i++)
		begin
			idx = chan_t'(last_q + i);
			if (!grant_valid_o && !empty_i[idx])
			begin
				grant_valid_o = 1'b1;
				grant_chan_o = idx;
			end
		end
	end

	// Starts at the top channel so channel 0 goes first
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			last_q <= chan_t'(NUM_CHANNELS - 1);
		else if (advance_i)
			last_q <= grant_chan_o;
	end

endmodule

`default_nettype wire

//--- hdl/packet_framer.sv
/*
	Packet framer: holds one 16-byte packet and steps through its bytes
*/
`timescale 1ns/1ps
`default_nettype none

module packet_framer import bt_link_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic load_i,
	input wire chan_t chan_i,
	input wire sample_t sample_i,
	input wire logic next_byte_i,
	output logic [7:0] byte_o,
	output logic last_byte_o
);

	packet_u packet_q;
	logic [BYTE_IDX_BITS-1:0] idx_q;

	// Channel number in both header and trailer
	always_ff @(posedge clock)
	begin
		if (load_i)
		begin
			packet_q.fields.header <= 8'(chan_i);
			packet_q.fields.pad <= '0;
			packet_q.fields.sample <= sample_i;
			packet_q.fields.trailer <= 8'(chan_i);
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			idx_q <= '0;
		else if (load_i)
			idx_q <= '0;
		else if (next_byte_i)
			idx_q <= idx_q + 1'b1;
	end

	assign byte_o = packet_q.bytes[idx_q];
	assign last_byte_o = (idx_q == BYTE_IDX_BITS'(PACKET_BYTES - 1));

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
/*
	UART transmitter, 8N1 with the bit length taken from an input
*/
`timescale 1ns/1ps
`default_nettype none

module uart_tx import bt_link_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic start_i,
	input wire logic [7:0] data_i,
	input wire logic [TIMER_BITS-1:0] cycles_per_bit_i,
	output logic txd_o,
	output logic done_o
);

	logic busy_q;
	logic [UART_FRAME_BITS-1:0] frame_q;
	logic [3:0] bit_q;
	logic [TIMER_BITS-1:0] tick_q;
	logic bit_end;
	logic last_bit;
	logic launch;

	assign launch = start_i && !busy_q;
	assign bit_end = (tick_q == cycles_per_bit_i - 1'b1);
	assign last_bit = (bit_q == 4'(UART_FRAME_BITS - 1));

	// Stop bit, data LSB first, start bit
	always_ff @(posedge clock)
	begin
		if (launch)
			frame_q <= {1'b1, data_i, 1'b0};
		else if (busy_q && bit_end)
			frame_q <= {1'b1, frame_q[UART_FRAME_BITS-1:1]};
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy_q <= 1'b0;
			bit_q <= '0;
			tick_q <= '0;
		end
		else if (launch)
		begin
			busy_q <= 1'b1;
			bit_q <= '0;
			tick_q <= '0;
		end
		else if (busy_q)
		begin
			if (bit_end)
			begin
				tick_q <= '0;
				bit_q <= bit_q + 1'b1;
				if (last_bit)
					busy_q <= 1'b0;
			end
			else
				tick_q <= tick_q + 1'b1;
		end
	end

	// Line idles high
	assign txd_o = busy_q ? frame_q[0] : 1'b1;
	// Last cycle of the stop bit
	assign done_o = busy_q && bit_end && last_bit;

endmodule

`default_nettype wire

//--- hdl/link_controller.sv
/*
	Transmit FSM: pops a sample, sends its packet byte by byte
	and spaces bytes and packets with the gap timers
*/
`timescale 1ns/1ps
`default_nettype none

module link_controller import bt_link_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic enable_i,
	input wire logic grant_valid_i,
	input wire logic [TIMER_BITS-1:0] byte_gap_i,
	input wire logic last_byte_i,
	input wire logic tx_done_i,
	output logic pop_o,
	output logic next_byte_o,
	output logic tx_start_o
);

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		SEND,
		WAIT_DONE,
		BYTE_GAP,
		PACKET_GAP
	} state_t;

	state_t state_q;
	state_t state_d;
	logic [GAP_BITS-1:0] gap_q;
	logic byte_gap_done;
	logic packet_gap_done;

	assign byte_gap_done = (gap_q >= GAP_BITS'(byte_gap_i));
	assign packet_gap_done = (gap_q >= GAP_BITS'(PACKET_GAP_CYCLES));

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			IDLE:
			begin
				// A packet already started always runs to its end
				if (enable_i && grant_valid_i)
					state_d = LOAD;
			end
			LOAD:
				state_d = SEND;
			SEND:
				state_d = WAIT_DONE;
			WAIT_DONE:
			begin
				if (tx_done_i)
					state_d = last_byte_i ? PACKET_GAP : BYTE_GAP;
			end
			BYTE_GAP:
			begin
				if (byte_gap_done)
					state_d = SEND;
			end
			PACKET_GAP:
			begin
				if (packet_gap_done)
					state_d = IDLE;
			end
			default:
				state_d = IDLE;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state_q <= IDLE;
			gap_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			// Gap counting starts at 1 in the cycle after done
			if (state_q == WAIT_DONE)
				gap_q <= GAP_BITS'(1);
			else if (state_q == BYTE_GAP || state_q == PACKET_GAP)
				gap_q <= gap_q + 1'b1;
		end
	end

	// FIFO pop and framer load share this strobe
	assign pop_o = (state_q == LOAD);
	assign tx_start_o = (state_q == SEND);
	assign next_byte_o = (state_q == BYTE_GAP) && byte_gap_done;

endmodule

`default_nettype wire

//--- hdl/bt_link_top.sv
/*
	Sensor to Bluetooth transmit link: channel FIFOs, arbiter,
	packet framer, FSM and UART transmitter
*/
`timescale 1ns/1ps
`default_nettype none

module bt_link_top import bt_link_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic enable_i,
	input wire logic [NUM_CHANNELS-1:0] sample_valid_i,
	input wire sample_t [NUM_CHANNELS-1:0] sample_data_i,
	input wire link_cfg_t cfg_i,
	output logic txd_o
);

	sample_t [NUM_CHANNELS-1:0] fifo_data;
	logic [NUM_CHANNELS-1:0] fifo_empty;
	logic [NUM_CHANNELS-1:0] fifo_rd;
	logic grant_valid;
	chan_t grant_chan;
	sample_t head_sample;
	logic pop;
	logic next_byte;
	logic [7:0] tx_byte;
	logic last_byte;
	logic tx_start;
	logic tx_done;

	for (genvar g = 0; g < NUM_CHANNELS; g++)
	begin : g_chan
		// Pop goes only to the granted channel
		assign fifo_rd[g] = pop && (grant_chan == chan_t'(g));

		sample_fifo i_sample_fifo (
			.clock(clock),
			.reset(reset),
			.wr_i(sample_valid_i[g]),
			.data_i(sample_data_i[g]),
			.rd_i(fifo_rd[g]),
			.data_o(fifo_data[g]),
			.empty_o(fifo_empty[g]),
			.full_o()
		);
	end

	assign head_sample = fifo_data[grant_chan];

	channel_arbiter i_channel_arbiter (
		.clock(clock),
		.reset(reset),
		.empty_i(fifo_empty),
		.advance_i(pop),
		.grant_valid_o(grant_valid),
		.grant_chan_o(grant_chan)
	);

	packet_framer i_packet_framer (
		.clock(clock),
		.reset(reset),
		.load_i(pop),
		.chan_i(grant_chan),
		.sample_i(head_sample),
		.next_byte_i(next_byte),
		.byte_o(tx_byte),
		.last_byte_o(last_byte)
	);

	link_controller i_link_controller (
		.clock(clock),
		.reset(reset),
		.enable_i(enable_i),
		.grant_valid_i(grant_valid),
		.byte_gap_i(cfg_i.byte_gap),
		.last_byte_i(last_byte),
		.tx_done_i(tx_done),
		.pop_o(pop),
		.next_byte_o(next_byte),
		.tx_start_o(tx_start)
	);

	uart_tx i_uart_tx (
		.clock(clock),
		.reset(reset),
		.start_i(tx_start),
		.data_i(tx_byte),
		.cycles_per_bit_i(cfg_i.cycles_per_bit),
		.txd_o(txd_o),
		.done_o(tx_done)
	);

endmodule

`default_nettype wire

//--- tb/tb_bt_link.sv
/*
	Testbench for the sensor to Bluetooth link: decodes the UART line
	and checks each packet against a reference model
*/
`timescale 1ns/1ps
`default_nettype none

module tb_bt_link
	import bt_link_pkg::*;
();

	localparam int BIT_CYCLES = 4;
	localparam int BYTE_GAP = 3;
	localparam int PACKETS_SENT = 13;
	localparam int PACKET_CYCLES =
		PACKET_BYTES * (UART_FRAME_BITS * BIT_CYCLES + BYTE_GAP) + PACKET_GAP_CYCLES;
	localparam int CYCLE_LIMIT = PACKETS_SENT * PACKET_CYCLES + 1000;

	logic clock;
	logic reset;
	logic enable;
	logic [NUM_CHANNELS-1:0] sample_valid;
	sample_t [NUM_CHANNELS-1:0] sample_data;
	link_cfg_t cfg;
	logic txd;

	logic [127:0] expected_q[$];
	logic [127:0] rx_q[$];
	sample_t pending [NUM_CHANNELS][2];
	int cycle_count = 0;
	int errors = 0;
	int checked_count = 0;
	int expected_total = 0;
	int gaps_checked = 0;
	int gap_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	bt_link_top i_bt_link_top (
		.clock(clock),
		.reset(reset),
		.enable_i(enable),
		.sample_valid_i(sample_valid),
		.sample_data_i(sample_data),
		.cfg_i(cfg),
		.txd_o(txd)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#4 clock = ~clock;
	end

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	initial
	begin
		while (cycle_count < CYCLE_LIMIT)
			@(posedge clock);
		$display("Timeout: no end of run after %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	// Byte 0 and byte 15 carry the channel, bytes 1 to 14 the padded sample
	function automatic logic [127:0] expected_packet(input int chan, input sample_t sample);
		logic [111:0] padded;
		logic [127:0] pkt;
		padded = {2'b00, sample};
		pkt[127:120] = 8'(chan);
		for (int i = 0; i < 14; i++)
			pkt[119-8*i -: 8] = padded[111-8*i -: 8];
		pkt[7:0] = 8'(chan);
		return pkt;
	endfunction

	function automatic sample_t random_sample();
		logic [127:0] r;
		r = {$urandom(), $urandom(), $urandom(), $urandom()};
		return r[SAMPLE_BITS-1:0];
	endfunction

	task automatic write_sample(input int chan, input sample_t sample);
		sample_valid[chan] = 1'b1;
		sample_data[chan] = sample;
		@(negedge clock);
		sample_valid = '0;
	endtask

	task automatic wait_for_packets();
		while (checked_count < expected_total)
			@(negedge clock);
	endtask

	task automatic report_test(input int num, input string name, input bit ok);
		if (ok)
			tests_passed++;
		else
			tests_failed++;
		$display("Test %0d %s: %s", num, name, ok ? "passed" : "FAILED");
	endtask

	// UART decoder, samples at mid-bit on the falling edge
	initial
	begin : line_receiver
		logic [7:0] rx_byte;
		logic [127:0] rx_packet;
		int byte_pos;
		int start_cycle;
		int last_end;
		int idle;
		byte_pos = 0;
		last_end = -1;
		rx_packet = '0;
		forever
		begin
			@(negedge clock);
			if (!reset && txd == 1'b0)
			begin
				start_cycle = cycle_count;
				if (last_end >= 0)
				begin
					idle = start_cycle - last_end;
					gaps_checked++;
					if (byte_pos != 0 && idle < BYTE_GAP)
					begin
						$display("[FAIL] %0t: byte gap of %0d cycles, expected at least %0d",
							$time, idle, BYTE_GAP);
						gap_errors++;
						errors++;
					end
					if (byte_pos == 0 && idle < PACKET_GAP_CYCLES)
					begin
						$display("[FAIL] %0t: packet gap of %0d cycles, expected at least %0d",
							$time, idle, PACKET_GAP_CYCLES);
						gap_errors++;
						errors++;
					end
				end
				last_end = start_cycle + UART_FRAME_BITS * BIT_CYCLES;
				repeat (BIT_CYCLES / 2) @(negedge clock);
				if (txd !== 1'b0)
				begin
					$display("[FAIL] %0t: start bit did not hold low", $time);
					errors++;
				end
				for (int b = 0; b < 8; b++)
				begin
					repeat (BIT_CYCLES) @(negedge clock);
					rx_byte[b] = txd;
				end
				repeat (BIT_CYCLES) @(negedge clock);
				if (txd !== 1'b1)
				begin
					$display("[FAIL] %0t: stop bit missing", $time);
					errors++;
				end
				rx_packet = {rx_packet[119:0], rx_byte};
				byte_pos++;
				if (byte_pos == PACKET_BYTES)
				begin
					rx_q.push_back(rx_packet);
					byte_pos = 0;
				end
			end
		end
	end

	// Compares received packets in arbitration order
	initial
	begin : packet_checker
		logic [127:0] got;
		logic [127:0] exp;
		forever
		begin
			@(posedge clock);
			if (rx_q.size() != 0)
			begin
				got = rx_q.pop_front();
				if (expected_q.size() == 0)
				begin
					$display("Packet received at %0t when none was expected", $time);
					errors++;
				end
				else
				begin
					exp = expected_q.pop_front();
					for (int i = 0; i < PACKET_BYTES; i++)
						if (got[127-8*i -: 8] !== exp[127-8*i -: 8])
						begin
							$display("[FAIL] %0t: packet %0d byte %0d is %02h, expected %02h",
								$time, checked_count, i, got[127-8*i -: 8], exp[127-8*i -: 8]);
							errors++;
						end
				end
				checked_count++;
			end
		end
	end

	initial
	begin : main
		sample_t s;
		int last_served;
		int err_start;
		int chan;
		logic line_busy;
		reset = 1'b1;
		enable = 1'b0;
		sample_valid = '0;
		sample_data = '0;
		cfg.cycles_per_bit = TIMER_BITS'(BIT_CYCLES);
		cfg.byte_gap = TIMER_BITS'(BYTE_GAP);
		void'($urandom(32'he459));
		last_served = NUM_CHANNELS - 1;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// Line stays idle with a sample stored and the link disabled
		err_start = errors;
		s = random_sample();
		write_sample(2, s);
		repeat (100)
		begin
			if (txd !== 1'b1)
			begin
				$display("[FAIL] %0t: txd_o low while disabled", $time);
				errors++;
			end
			@(negedge clock);
		end
		report_test(1, "idle while disabled", errors == err_start);

		err_start = errors;
		expected_q.push_back(expected_packet(2, s));
		expected_total++;
		last_served = 2;
		enable = 1'b1;
		wait_for_packets();
		enable = 1'b0;
		report_test(2, "single packet on channel 2", errors == err_start);

		// Two samples per channel, sent twice round
		err_start = errors;
		for (int n = 0; n < 2; n++)
		begin
			for (int c = 0; c < NUM_CHANNELS; c++)
			begin
				pending[c][n] = random_sample();
				sample_data[c] = pending[c][n];
			end
			sample_valid = '1;
			@(negedge clock);
		end
		sample_valid = '0;
		for (int n = 0; n < 2; n++)
			for (int k = 1; k <= NUM_CHANNELS; k++)
			begin
				chan = (last_served + k) % NUM_CHANNELS;
				expected_q.push_back(expected_packet(chan, pending[chan][n]));
				expected_total++;
			end
		enable = 1'b1;
		wait_for_packets();
		enable = 1'b0;
		report_test(3, "round-robin order", errors == err_start);

		// Writes beyond the FIFO depth are lost
		err_start = errors;
		for (int n = 0; n < 6; n++)
		begin
			s = random_sample();
			if (n < FIFO_DEPTH)
			begin
				expected_q.push_back(expected_packet(1, s));
				expected_total++;
			end
			write_sample(1, s);
		end
		enable = 1'b1;
		wait_for_packets();
		// A dropped sample would start a fifth packet well inside this window
		line_busy = 1'b0;
		repeat (200)
		begin
			@(negedge clock);
			if (txd !== 1'b1)
				line_busy = 1'b1;
		end
		if (line_busy)
		begin
			$display("[FAIL] %0t: line active after the last expected packet", $time);
			errors++;
		end
		enable = 1'b0;
		report_test(4, "full FIFO drops samples", errors == err_start);

		report_test(5, "byte and packet gaps", gap_errors == 0 && gaps_checked > 0);

		$display("Tests passed: %0d, failed: %0d, errors: %0d, packets checked: %0d",
			tests_passed, tests_failed, errors, checked_count);
		if (errors == 0 && tests_failed == 0 && expected_q.size() == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
hdl/bt_link_pkg.sv
hdl/sample_fifo.sv
hdl/channel_arbiter.sv
hdl/packet_framer.sv
hdl/uart_tx.sv
hdl/link_controller.sv
hdl/bt_link_top.sv
tb/tb_bt_link.sv

//--- run.sh
#!/usr/bin/env bash
# Build the bt_link testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_bt_link -o sim_bt_link \
	|| { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/sim_bt_link) && echo "$sim_out" \
	|| { echo "$sim_out"; echo "Simulation run aborted"; exit 1; }

echo "$sim_out" | grep -q "Simulation completed successfully" && exit 0 || exit 1
